// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN = 32;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU operations, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Load widths
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Store widths
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Alternate form selects SUB and SRA/SRAI
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // Same 32-bit word seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } instr_u;

endpackage

// ==== hw/ex_ctl_pkg.sv ====
package ex_ctl_pkg;

    localparam int ALU_W = 4;
    localparam int IMM_W = 4;

    // ALU operation codes as the execute-stage ALU expects them
    localparam logic [ALU_W-1:0] ALU_AND    = 4'b0000;
    localparam logic [ALU_W-1:0] ALU_OR     = 4'b0001;
    localparam logic [ALU_W-1:0] ALU_XOR    = 4'b0010;
    localparam logic [ALU_W-1:0] ALU_ADD    = 4'b0011;
    localparam logic [ALU_W-1:0] ALU_SUB    = 4'b0100;

    // Operand B straight through, used by LUI
    localparam logic [ALU_W-1:0] ALU_PASS_B = 4'b0110;

    localparam logic [ALU_W-1:0] ALU_SLL    = 4'b0111;
    localparam logic [ALU_W-1:0] ALU_SRL    = 4'b1000;
    localparam logic [ALU_W-1:0] ALU_SRA    = 4'b1010;

    // Compare results, 1 or 0 in bit 0
    localparam logic [ALU_W-1:0] ALU_SLTU   = 4'b1011;
    localparam logic [ALU_W-1:0] ALU_SLT    = 4'b1100;

    // Immediate generator formats
    localparam logic [IMM_W-1:0] IMM_NONE = 4'd0;
    localparam logic [IMM_W-1:0] IMM_I    = 4'd1;
    localparam logic [IMM_W-1:0] IMM_S    = 4'd2;
    localparam logic [IMM_W-1:0] IMM_B    = 4'd3;
    localparam logic [IMM_W-1:0] IMM_U    = 4'd4;
    localparam logic [IMM_W-1:0] IMM_J    = 4'd5;

endpackage

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder (
    input  rv_isa_pkg::instr_u              instruction,
    output logic                            a_sel,
    output logic                            b_sel,
    output logic [ex_ctl_pkg::IMM_W-1:0]    imm_sel,
    output logic [ex_ctl_pkg::ALU_W-1:0]    alu_sel,
    output logic                            br_un
);

    logic [6:0]                     opcode;
    logic [2:0]                     funct3;
    logic                           is_op;
    logic [6:0]                     arith_f7;
    logic                           f7_base;
    logic                           f7_alt;
    logic [ex_ctl_pkg::ALU_W-1:0]   arith_alu;
    logic                           arith_ok;

    assign opcode = instruction.r_view.opcode;
    assign funct3 = instruction.r_view.funct3;
    assign is_op  = (opcode == rv_isa_pkg::OPC_OP);

    // OP-IMM shifts hold shamt in imm12[4:0], qualifier sits above it
    assign arith_f7 = is_op ? instruction.r_view.funct7
                            : instruction.i_view.imm12[11:5];

    assign f7_base = (arith_f7 == rv_isa_pkg::F7_BASE);
    assign f7_alt  = (arith_f7 == rv_isa_pkg::F7_ALT);

    // funct3 to ALU op, common to OP and OP-IMM
    always_comb begin
        arith_alu = ex_ctl_pkg::ALU_AND;
        // Register form needs a clean funct7 unless the alternate is allowed
        arith_ok  = !is_op || f7_base;
        case (funct3)
            rv_isa_pkg::F3_ADD: begin
                if (is_op && f7_alt) begin
                    arith_alu = ex_ctl_pkg::ALU_SUB;
                    arith_ok  = 1'b1;
                end else begin
                    arith_alu = ex_ctl_pkg::ALU_ADD;
                end
            end
            rv_isa_pkg::F3_SLL: begin
                arith_alu = ex_ctl_pkg::ALU_SLL;
            end
            rv_isa_pkg::F3_SLT: begin
                arith_alu = ex_ctl_pkg::ALU_SLT;
            end
            rv_isa_pkg::F3_SLTU: begin
                arith_alu = ex_ctl_pkg::ALU_SLTU;
            end
            rv_isa_pkg::F3_XOR: begin
                arith_alu = ex_ctl_pkg::ALU_XOR;
            end
            rv_isa_pkg::F3_SR: begin
                // Logical or arithmetic, for both register and immediate forms
                arith_ok  = f7_base || f7_alt;
                arith_alu = f7_alt ? ex_ctl_pkg::ALU_SRA : ex_ctl_pkg::ALU_SRL;
            end
            rv_isa_pkg::F3_OR: begin
                arith_alu = ex_ctl_pkg::ALU_OR;
            end
            rv_isa_pkg::F3_AND: begin
                arith_alu = ex_ctl_pkg::ALU_AND;
            end
        endcase
    end

    always_comb begin
        // Anything unrecognised leaves the all-zero controls
        a_sel   = 1'b0;
        b_sel   = 1'b0;
        imm_sel = ex_ctl_pkg::IMM_NONE;
        alu_sel = ex_ctl_pkg::ALU_AND;
        br_un   = 1'b0;

        case (opcode)
            rv_isa_pkg::OPC_LUI: begin
                b_sel   = 1'b1;
                imm_sel = ex_ctl_pkg::IMM_U;
                alu_sel = ex_ctl_pkg::ALU_PASS_B;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = ex_ctl_pkg::IMM_U;
                alu_sel = ex_ctl_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_JAL: begin
                // Target is PC plus J immediate
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = ex_ctl_pkg::IMM_J;
                alu_sel = ex_ctl_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_JALR: begin
                // Target is rs1 plus I immediate
                b_sel   = 1'b1;
                imm_sel = ex_ctl_pkg::IMM_I;
                alu_sel = ex_ctl_pkg::ALU_ADD;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                case (funct3)
                    rv_isa_pkg::F3_BEQ,
                    rv_isa_pkg::F3_BNE,
                    rv_isa_pkg::F3_BLT,
                    rv_isa_pkg::F3_BGE: begin
                        imm_sel = ex_ctl_pkg::IMM_B;
                        alu_sel = ex_ctl_pkg::ALU_ADD;
                    end
                    rv_isa_pkg::F3_BLTU,
                    rv_isa_pkg::F3_BGEU: begin
                        imm_sel = ex_ctl_pkg::IMM_B;
                        alu_sel = ex_ctl_pkg::ALU_ADD;
                        br_un   = 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
            rv_isa_pkg::OPC_LOAD: begin
                case (funct3)
                    rv_isa_pkg::F3_LB,
                    rv_isa_pkg::F3_LH,
                    rv_isa_pkg::F3_LW,
                    rv_isa_pkg::F3_LBU,
                    rv_isa_pkg::F3_LHU: begin
                        b_sel   = 1'b1;
                        imm_sel = ex_ctl_pkg::IMM_I;
                        alu_sel = ex_ctl_pkg::ALU_ADD;
                    end
                    default: begin
                    end
                endcase
            end
            rv_isa_pkg::OPC_STORE: begin
                case (funct3)
                    rv_isa_pkg::F3_SB,
                    rv_isa_pkg::F3_SH,
                    rv_isa_pkg::F3_SW: begin
                        b_sel   = 1'b1;
                        imm_sel = ex_ctl_pkg::IMM_S;
                        alu_sel = ex_ctl_pkg::ALU_ADD;
                    end
                    default: begin
                    end
                endcase
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                if (arith_ok) begin
                    b_sel   = 1'b1;
                    imm_sel = ex_ctl_pkg::IMM_I;
                    alu_sel = arith_alu;
                end
            end
            rv_isa_pkg::OPC_OP: begin
                if (arith_ok) begin
                    alu_sel = arith_alu;
                end
            end
            // FENCE and SYSTEM land here as well
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver (
    input  rv_isa_pkg::instr_u  instruction,
    input  logic                br_eq,
    input  logic                br_lt,
    output logic                pc_sel
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instruction.r_view.opcode;
    assign funct3 = instruction.r_view.funct3;

    always_comb begin
        pc_sel = 1'b0;
        case (opcode)
            rv_isa_pkg::OPC_JAL,
            rv_isa_pkg::OPC_JALR: begin
                pc_sel = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                // br_lt already reflects br_un from the decoder
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  pc_sel = br_eq;
                    rv_isa_pkg::F3_BNE:  pc_sel = !br_eq;
                    rv_isa_pkg::F3_BLT,
                    rv_isa_pkg::F3_BLTU: pc_sel = br_lt;
                    rv_isa_pkg::F3_BGE,
                    rv_isa_pkg::F3_BGEU: pc_sel = !br_lt;
                    // 010 and 011 are not branches
                    default:             pc_sel = 1'b0;
                endcase
            end
            default: begin
                pc_sel = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/execute_ctl.sv ====
`timescale 1ns/1ps

module execute_ctl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic                            br_eq,
    input  logic                            br_lt,
    input  logic [rv_isa_pkg::XLEN-1:0]     instruction,
    input  logic [rv_isa_pkg::XLEN-1:0]     data_a,
    input  logic [rv_isa_pkg::XLEN-1:0]     data_b,
    input  logic [rv_isa_pkg::XLEN-1:0]     pc_de,
    output logic                            in_ready,
    input  logic                            out_ready,
    output logic                            out_valid,
    output logic                            a_sel,
    output logic                            b_sel,
    output logic                            br_un,
    output logic                            pc_sel,
    output logic [ex_ctl_pkg::IMM_W-1:0]    imm_sel,
    output logic [ex_ctl_pkg::ALU_W-1:0]    alu_sel,
    output logic [rv_isa_pkg::XLEN-1:0]     data_a_exe,
    output logic [rv_isa_pkg::XLEN-1:0]     data_b_exe,
    output logic [rv_isa_pkg::XLEN-1:0]     pc_exe,
    output logic [rv_isa_pkg::XLEN-1:0]     instr_exe
);

    logic                           dec_a_sel;
    logic                           dec_b_sel;
    logic                           dec_br_un;
    logic [ex_ctl_pkg::IMM_W-1:0]   dec_imm_sel;
    logic [ex_ctl_pkg::ALU_W-1:0]   dec_alu_sel;
    logic                           res_pc_sel;
    logic                           accept;

    instr_decoder u_decoder (
        .instruction (instruction),
        .a_sel       (dec_a_sel),
        .b_sel       (dec_b_sel),
        .imm_sel     (dec_imm_sel),
        .alu_sel     (dec_alu_sel),
        .br_un       (dec_br_un)
    );

    branch_resolver u_resolver (
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .pc_sel      (res_pc_sel)
    );

    // Single-entry stage, refills on the same edge it drains
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid  <= 1'b0;
            a_sel      <= 1'b0;
            b_sel      <= 1'b1;
            imm_sel    <= ex_ctl_pkg::IMM_NONE;
            alu_sel    <= ex_ctl_pkg::ALU_PASS_B;
            br_un      <= 1'b0;
            pc_sel     <= 1'b0;
            data_a_exe <= '0;
            data_b_exe <= '0;
            pc_exe     <= '0;
            instr_exe  <= '0;
        end else begin
            if (accept) begin
                out_valid  <= 1'b1;
                a_sel      <= dec_a_sel;
                b_sel      <= dec_b_sel;
                imm_sel    <= dec_imm_sel;
                alu_sel    <= dec_alu_sel;
                br_un      <= dec_br_un;
                pc_sel     <= res_pc_sel;
                data_a_exe <= data_a;
                data_b_exe <= data_b;
                pc_exe     <= pc_de;
                instr_exe  <= instruction;
            end else if (out_ready) begin
                // Consumed with nothing behind it
                out_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== bench/execute_ctl_tb.sv ====
`timescale 1ns/1ps

module execute_ctl_tb;

    typedef struct packed {
        logic        a_sel;
        logic        b_sel;
        logic [3:0]  imm_sel;
        logic [3:0]  alu_sel;
        logic        br_un;
        logic        pc_sel;
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic [31:0] pc;
        logic [31:0] instr;
    } exp_item_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        br_eq;
    logic        br_lt;
    logic [31:0] instruction;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] pc_de;
    logic        in_ready;
    logic        out_ready;
    logic        out_valid;
    logic        a_sel;
    logic        b_sel;
    logic        br_un;
    logic        pc_sel;
    logic [3:0]  imm_sel;
    logic [3:0]  alu_sel;
    logic [31:0] data_a_exe;
    logic [31:0] data_b_exe;
    logic [31:0] pc_exe;
    logic [31:0] instr_exe;

    integer      seed = 32'hc798;
    exp_item_t   exp_q[$];
    string       test_name = "none";
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          stall_cycles = 0;
    logic        bp_mode = 1'b0;

    execute_ctl uut (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .br_eq      (br_eq),
        .br_lt      (br_lt),
        .instruction(instruction),
        .data_a     (data_a),
        .data_b     (data_b),
        .pc_de      (pc_de),
        .in_ready   (in_ready),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .a_sel      (a_sel),
        .b_sel      (b_sel),
        .br_un      (br_un),
        .pc_sel     (pc_sel),
        .imm_sel    (imm_sel),
        .alu_sel    (alu_sel),
        .data_a_exe (data_a_exe),
        .data_b_exe (data_b_exe),
        .pc_exe     (pc_exe),
        .instr_exe  (instr_exe)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: test %s, %s expected %h actual %h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout in test %s: %s", test_name, why);
        $display("TESTS FAILED");
        $finish;
    endtask

    // Operation for OP and OP-IMM from funct3, SUB only in register form
    function automatic logic [3:0] arith_op(input logic [2:0] f3, input logic [6:0] f7,
                                            input logic reg_form);
        case (f3)
            rv_isa_pkg::F3_ADD:  arith_op = (reg_form && f7 == rv_isa_pkg::F7_ALT) ?
                                            ex_ctl_pkg::ALU_SUB : ex_ctl_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  arith_op = ex_ctl_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  arith_op = ex_ctl_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: arith_op = ex_ctl_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  arith_op = ex_ctl_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   arith_op = (f7 == rv_isa_pkg::F7_ALT) ?
                                            ex_ctl_pkg::ALU_SRA : ex_ctl_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   arith_op = ex_ctl_pkg::ALU_OR;
            default:             arith_op = ex_ctl_pkg::ALU_AND;
        endcase
    endfunction

    function automatic exp_item_t model_item(input logic [31:0] w, input logic eq,
                                             input logic lt, input logic [31:0] a,
                                             input logic [31:0] b, input logic [31:0] pc);
        exp_item_t  it;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        opc = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        // Zero fill is the default row
        it = '0;
        it.data_a = a;
        it.data_b = b;
        it.pc = pc;
        it.instr = w;
        if (opc == rv_isa_pkg::OPC_LUI) begin
            it.b_sel = 1'b1;
            it.imm_sel = ex_ctl_pkg::IMM_U;
            it.alu_sel = ex_ctl_pkg::ALU_PASS_B;
        end else if (opc == rv_isa_pkg::OPC_AUIPC || opc == rv_isa_pkg::OPC_JAL) begin
            it.a_sel = 1'b1;
            it.b_sel = 1'b1;
            it.imm_sel = (opc == rv_isa_pkg::OPC_JAL) ? ex_ctl_pkg::IMM_J : ex_ctl_pkg::IMM_U;
            it.alu_sel = ex_ctl_pkg::ALU_ADD;
            it.pc_sel = (opc == rv_isa_pkg::OPC_JAL);
        end else if (opc == rv_isa_pkg::OPC_JALR) begin
            it.b_sel = 1'b1;
            it.imm_sel = ex_ctl_pkg::IMM_I;
            it.alu_sel = ex_ctl_pkg::ALU_ADD;
            it.pc_sel = 1'b1;
        end else if (opc == rv_isa_pkg::OPC_BRANCH) begin
            if (f3 != 3'b010 && f3 != 3'b011) begin
                it.imm_sel = ex_ctl_pkg::IMM_B;
                it.alu_sel = ex_ctl_pkg::ALU_ADD;
                it.br_un = f3[2] & f3[1];
                // Bit 2 picks lt over eq, bit 0 inverts the condition
                it.pc_sel = (f3[2] ? lt : eq) ^ f3[0];
            end
        end else if (opc == rv_isa_pkg::OPC_LOAD) begin
            if (f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111) begin
                it.b_sel = 1'b1;
                it.imm_sel = ex_ctl_pkg::IMM_I;
                it.alu_sel = ex_ctl_pkg::ALU_ADD;
            end
        end else if (opc == rv_isa_pkg::OPC_STORE) begin
            if (f3 <= 3'b010) begin
                it.b_sel = 1'b1;
                it.imm_sel = ex_ctl_pkg::IMM_S;
                it.alu_sel = ex_ctl_pkg::ALU_ADD;
            end
        end else if (opc == rv_isa_pkg::OPC_OP_IMM) begin
            if (f3 != rv_isa_pkg::F3_SR || f7 == rv_isa_pkg::F7_BASE ||
                f7 == rv_isa_pkg::F7_ALT) begin
                it.b_sel = 1'b1;
                it.imm_sel = ex_ctl_pkg::IMM_I;
                it.alu_sel = arith_op(f3, f7, 1'b0);
            end
        end else if (opc == rv_isa_pkg::OPC_OP) begin
            if (f7 == rv_isa_pkg::F7_BASE || (f7 == rv_isa_pkg::F7_ALT &&
                (f3 == rv_isa_pkg::F3_ADD || f3 == rv_isa_pkg::F3_SR))) begin
                it.alu_sel = arith_op(f3, f7, 1'b1);
            end
        end
        return it;
    endfunction

    // Scoreboard, sampled on the rising edge
    always @(posedge clk) begin
        exp_item_t front;
        if (!rst) begin
            // Register is empty exactly when no accepted item is still waiting
            check_value("in_ready", (exp_q.size() == 0) || out_ready, in_ready);
            if (exp_q.size() == 0) begin
                check_value("out_valid with nothing accepted", 0, out_valid);
            end else begin
                front = exp_q[0];
                check_value("out_valid", 1, out_valid);
                check_value("a_sel", front.a_sel, a_sel);
                check_value("b_sel", front.b_sel, b_sel);
                check_value("imm_sel", front.imm_sel, imm_sel);
                check_value("alu_sel", front.alu_sel, alu_sel);
                check_value("br_un", front.br_un, br_un);
                check_value("pc_sel", front.pc_sel, pc_sel);
                check_value("data_a_exe", front.data_a, data_a_exe);
                check_value("data_b_exe", front.data_b, data_b_exe);
                check_value("pc_exe", front.pc, pc_exe);
                check_value("instr_exe", front.instr, instr_exe);
                if (out_valid && out_ready) begin
                    void'(exp_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(model_item(instruction, br_eq, br_lt, data_a, data_b, pc_de));
            end
        end
    end

    task automatic next_negedge();
        logic [31:0] r;
        @(negedge clk);
        if (bp_mode) begin
            r = $random(seed);
            out_ready = r[0];
        end else begin
            out_ready = 1'b1;
        end
    endtask

    task automatic send(input logic [31:0] word, input logic eq, input logic lt);
        int waited;
        waited = 0;
        next_negedge();
        in_valid = 1'b1;
        instruction = word;
        data_a = $random(seed);
        data_b = $random(seed);
        pc_de = $random(seed);
        br_eq = eq;
        br_lt = lt;
        @(posedge clk);
        while (!in_ready) begin
            waited++;
            stall_cycles++;
            if (waited > 50) begin
                abort_run("in_valid was never accepted by in_ready");
            end
            next_negedge();
            @(posedge clk);
        end
    endtask

    task automatic send_rand(input logic [31:0] word);
        logic [31:0] r;
        r = $random(seed);
        send(word, r[0], r[1]);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            next_negedge();
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        bp_mode = 1'b0;
        idle(1);
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 100) begin
                abort_run("accepted items never left through out_valid/out_ready");
            end
            idle(1);
        end
    endtask

    function automatic logic [31:0] any_word(input logic [2:0] f3, input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [6:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {f7, r[24:15], f3, r[11:7], opc};
    endfunction

    function automatic logic [31:0] mixed_word();
        logic [31:0] r;
        logic [6:0]  opc;
        r = $random(seed);
        case ($unsigned($random(seed)) % 10)
            0: opc = rv_isa_pkg::OPC_LUI;
            1: opc = rv_isa_pkg::OPC_AUIPC;
            2: opc = rv_isa_pkg::OPC_JAL;
            3: opc = rv_isa_pkg::OPC_JALR;
            4: opc = rv_isa_pkg::OPC_BRANCH;
            5: opc = rv_isa_pkg::OPC_LOAD;
            6: opc = rv_isa_pkg::OPC_STORE;
            7: opc = rv_isa_pkg::OPC_OP_IMM;
            8: opc = rv_isa_pkg::OPC_OP;
            default: opc = r[6:0];
        endcase
        return {r[31:7], opc};
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        return opc inside {rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC, rv_isa_pkg::OPC_JAL,
                           rv_isa_pkg::OPC_JALR, rv_isa_pkg::OPC_BRANCH, rv_isa_pkg::OPC_LOAD,
                           rv_isa_pkg::OPC_STORE, rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_OP};
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        drain();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("Test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    initial begin
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [31:0] r;
        int          n;
        rst = 1'b1;
        in_valid = 1'b0;
        br_eq = 1'b0;
        br_lt = 1'b0;
        instruction = '0;
        data_a = '0;
        data_b = '0;
        pc_de = '0;
        out_ready = 1'b1;

        begin_test("reset");
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("out_valid", 0, out_valid);
        check_value("pc_sel", 0, pc_sel);
        check_value("a_sel", 0, a_sel);
        check_value("b_sel", 1, b_sel);
        check_value("imm_sel", ex_ctl_pkg::IMM_NONE, imm_sel);
        check_value("alu_sel", ex_ctl_pkg::ALU_PASS_B, alu_sel);
        check_value("br_un", 0, br_un);
        check_value("data_a_exe", 0, data_a_exe);
        check_value("data_b_exe", 0, data_b_exe);
        check_value("pc_exe", 0, pc_exe);
        check_value("instr_exe", 0, instr_exe);
        check_value("in_ready", 1, in_ready);
        end_test();

        begin_test("decode_table");
        repeat (4) begin
            send_rand(mixed_word() & 32'hffff_ff80 | rv_isa_pkg::OPC_LUI);
            send_rand(any_word(3'b000, rv_isa_pkg::OPC_AUIPC));
            send_rand(any_word(3'b000, rv_isa_pkg::OPC_JAL));
            send_rand(any_word(3'b000, rv_isa_pkg::OPC_JALR));
            for (int f = 0; f < 8; f++) begin
                if (f != 3 && f != 6 && f != 7) begin
                    send_rand(any_word(f[2:0], rv_isa_pkg::OPC_LOAD));
                end
                if (f < 3) begin
                    send_rand(any_word(f[2:0], rv_isa_pkg::OPC_STORE));
                end
                if (f == 1 || f == 5) begin
                    // Shift immediates, random shamt
                    send_rand(r_word(rv_isa_pkg::F7_BASE, f[2:0], rv_isa_pkg::OPC_OP_IMM));
                end else begin
                    send_rand(any_word(f[2:0], rv_isa_pkg::OPC_OP_IMM));
                end
                send_rand(r_word(rv_isa_pkg::F7_BASE, f[2:0], rv_isa_pkg::OPC_OP));
            end
            send_rand(r_word(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP_IMM));
            send_rand(r_word(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_ADD, rv_isa_pkg::OPC_OP));
            send_rand(r_word(rv_isa_pkg::F7_ALT, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP));
        end
        end_test();

        begin_test("branches");
        for (int c = 0; c < 4; c++) begin
            for (int f = 0; f < 8; f++) begin
                if (f != 2 && f != 3) begin
                    send(any_word(f[2:0], rv_isa_pkg::OPC_BRANCH), c[0], c[1]);
                end
            end
            send(any_word(3'b000, rv_isa_pkg::OPC_JAL), c[0], c[1]);
            send(any_word(3'b000, rv_isa_pkg::OPC_JALR), c[0], c[1]);
        end
        end_test();

        begin_test("default");
        n = 0;
        for (int tries = 0; tries < 200 && n < 12; tries++) begin
            r = $random(seed);
            opc = r[6:0];
            if (!known_opcode(opc)) begin
                send_rand(r);
                n++;
            end
        end
        for (int f = 3; f < 8; f++) begin
            if (f == 3 || f > 5) begin
                send_rand(any_word(f[2:0], rv_isa_pkg::OPC_LOAD));
            end
            send_rand(any_word(f[2:0], rv_isa_pkg::OPC_STORE));
        end
        send_rand(any_word(3'b010, rv_isa_pkg::OPC_BRANCH));
        send_rand(any_word(3'b011, rv_isa_pkg::OPC_BRANCH));
        for (int f = 0; f < 8; f++) begin
            r = $random(seed);
            f7 = r[6:0];
            if (f7 == rv_isa_pkg::F7_BASE || f7 == rv_isa_pkg::F7_ALT) begin
                f7 = 7'h7f;
            end
            send_rand(r_word(f7, f[2:0], rv_isa_pkg::OPC_OP));
            if (f != 0 && f != 5) begin
                send_rand(r_word(rv_isa_pkg::F7_ALT, f[2:0], rv_isa_pkg::OPC_OP));
            end
        end
        send_rand(r_word(7'b0000001, rv_isa_pkg::F3_SR, rv_isa_pkg::OPC_OP_IMM));
        send_rand(any_word(3'b000, 7'b0001111));
        send_rand(32'h0000_0073);
        send_rand(32'h0010_0073);
        end_test();

        begin_test("pass_through");
        stall_cycles = 0;
        repeat (24) send_rand(mixed_word());
        // Ready held high, so every offer goes in on its first edge
        check_value("stall cycles", 0, stall_cycles);
        end_test();

        begin_test("back_pressure");
        bp_mode = 1'b1;
        repeat (60) begin
            if ($unsigned($random(seed)) % 3 == 0) idle(1 + $unsigned($random(seed)) % 3);
            send_rand(mixed_word());
        end
        end_test();

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hw/rv_isa_pkg.sv
hw/ex_ctl_pkg.sv
hw/instr_decoder.sv
hw/branch_resolver.sv
hw/execute_ctl.sv
bench/execute_ctl_tb.sv

// ==== Bender.yml ====
package:
  name: execute_ctl

dependencies: {}

sources:
  - hw/rv_isa_pkg.sv
  - hw/ex_ctl_pkg.sv
  - hw/instr_decoder.sv
  - hw/branch_resolver.sv
  - hw/execute_ctl.sv
  - target: test
    files:
      - bench/execute_ctl_tb.sv
